// File: common/mmu_cfg.svh
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// tlb geometry
`define TLB_NUM     16
`define TLB_IDX_W   4

// entry field widths
`define ASID_W      10
`define PFN_W       20
`define VPN2_W      19
`define PS_W        6

// page size codes as log2 of the page size
`define PS_4K       6'd12
`define PS_2M       6'd21

// access types
`define MEM_LOAD    2'd0
`define MEM_STORE   2'd1
`define MEM_FETCH   2'd2

// exception codes
`define EXC_NONE    3'd0
`define EXC_TLBR    3'd1
`define EXC_PIL     3'd2
`define EXC_PIS     3'd3
`define EXC_PIF     3'd4
`define EXC_PME     3'd5
`define EXC_PPI     3'd6

`endif

// File: common/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    // window view as segment plus offset
    typedef struct packed {
        logic [2:0]  vseg;
        logic [28:0] offset;
    } win_view_t;

    // page view for 4 KB pairs
    typedef struct packed {
        logic [18:0] vpn2;
        logic        odd;
        logic [11:0] pg_off;
    } page_view_t;

    typedef union packed {
        win_view_t  win;
        page_view_t page;
    } vaddr_u;

endpackage

`default_nettype wire

// File: files.f
+incdir+common
common/mmu_pkg.sv
tlb/tlb_array.sv
tlb/tlb_match.sv
verilog/dmw_check.sv
verilog/lookup_req.sv
verilog/xlat_resp.sv
verilog/mmu_top.sv
verification/mmu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mmu testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f files.f --top-module mmu_tb -o mmu_sim \
    && ./obj_dir/mmu_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "\*\*\* TEST PASSED \*\*\*" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tlb/tlb_array.sv
`default_nettype none
`include "mmu_cfg.svh"

module tlb_array (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           tlb_we,
    input  logic [`TLB_IDX_W-1:0]          tlb_windex,
    input  logic [`VPN2_W-1:0]             tlb_wvpn2,
    input  logic [`ASID_W-1:0]             tlb_wasid,
    input  logic [`PS_W-1:0]               tlb_wps,
    input  logic                           tlb_we_bit,
    input  logic                           tlb_wg,
    input  logic [`PFN_W-1:0]              tlb_wpfn0,
    input  logic [1:0]                     tlb_wmat0,
    input  logic [1:0]                     tlb_wplv0,
    input  logic                           tlb_wd0,
    input  logic                           tlb_wv0,
    input  logic [`PFN_W-1:0]              tlb_wpfn1,
    input  logic [1:0]                     tlb_wmat1,
    input  logic [1:0]                     tlb_wplv1,
    input  logic                           tlb_wd1,
    input  logic                           tlb_wv1,
    input  logic                           inv_valid,
    input  logic [2:0]                     inv_op,
    input  logic [`ASID_W-1:0]             inv_asid,
    input  logic [31:0]                    inv_vaddr,
    output logic [`TLB_NUM-1:0]            ent_e,
    output logic [`TLB_NUM-1:0]            ent_g,
    output logic [`TLB_NUM*`ASID_W-1:0]    ent_asid,
    output logic [`TLB_NUM*`VPN2_W-1:0]    ent_vpn2,
    output logic [`TLB_NUM*`PS_W-1:0]      ent_ps,
    output logic [`TLB_NUM*`PFN_W-1:0]     ent_pfn0,
    output logic [`TLB_NUM*2-1:0]          ent_mat0,
    output logic [`TLB_NUM*2-1:0]          ent_plv0,
    output logic [`TLB_NUM-1:0]            ent_d0,
    output logic [`TLB_NUM-1:0]            ent_v0,
    output logic [`TLB_NUM*`PFN_W-1:0]     ent_pfn1,
    output logic [`TLB_NUM*2-1:0]          ent_mat1,
    output logic [`TLB_NUM*2-1:0]          ent_plv1,
    output logic [`TLB_NUM-1:0]            ent_d1,
    output logic [`TLB_NUM-1:0]            ent_v1
);
    localparam int N = `TLB_NUM;

    logic [N-1:0]             e_q;
    logic [N-1:0]             g_q;
    logic [`ASID_W-1:0]       asid_q [N];
    logic [`VPN2_W-1:0]       vpn2_q [N];
    logic [`PS_W-1:0]         ps_q [N];
    logic [`PFN_W-1:0]        pfn_q [N][2];
    logic [1:0]               mat_q [N][2];
    logic [1:0]               plv_q [N][2];
    logic [1:0][N-1:0]        d_q;
    logic [1:0][N-1:0]        v_q;
    logic [N-1:0]             asid_eq;
    logic [N-1:0]             vpn_eq;
    logic [N-1:0]             inv_hit;

    for (genvar i = 0; i < N; i++) begin : g_ent
        assign asid_eq[i] = asid_q[i] == inv_asid;
        assign vpn_eq[i]  = vpn2_q[i] == inv_vaddr[31:13];
        assign ent_asid[i*`ASID_W +: `ASID_W] = asid_q[i];
        assign ent_vpn2[i*`VPN2_W +: `VPN2_W] = vpn2_q[i];
        assign ent_ps[i*`PS_W +: `PS_W]       = ps_q[i];
        assign ent_pfn0[i*`PFN_W +: `PFN_W]   = pfn_q[i][0];
        assign ent_pfn1[i*`PFN_W +: `PFN_W]   = pfn_q[i][1];
        assign ent_mat0[i*2 +: 2]             = mat_q[i][0];
        assign ent_mat1[i*2 +: 2]             = mat_q[i][1];
        assign ent_plv0[i*2 +: 2]             = plv_q[i][0];
        assign ent_plv1[i*2 +: 2]             = plv_q[i][1];
    end

    assign ent_e  = e_q;
    assign ent_g  = g_q;
    assign ent_d0 = d_q[0];
    assign ent_d1 = d_q[1];
    assign ent_v0 = v_q[0];
    assign ent_v1 = v_q[1];

    // invtlb select per entry
    always_comb begin
        case (inv_op)
            3'd0, 3'd1: inv_hit = '1;
            3'd2:       inv_hit = g_q;
            3'd3:       inv_hit = ~g_q;
            3'd4:       inv_hit = ~g_q & asid_eq;
            3'd5:       inv_hit = ~g_q & asid_eq & vpn_eq;
            3'd6:       inv_hit = (g_q | asid_eq) & vpn_eq;
            default:    inv_hit = '0;
        endcase
    end

    // a write in the same cycle wins for its own index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_q <= '0;
        end else begin
            if (inv_valid)
                e_q <= e_q & ~inv_hit;
            if (tlb_we)
                e_q[tlb_windex] <= tlb_we_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            g_q[tlb_windex]       <= tlb_wg;
            asid_q[tlb_windex]    <= tlb_wasid;
            vpn2_q[tlb_windex]    <= tlb_wvpn2;
            ps_q[tlb_windex]      <= tlb_wps;
            pfn_q[tlb_windex][0]  <= tlb_wpfn0;
            pfn_q[tlb_windex][1]  <= tlb_wpfn1;
            mat_q[tlb_windex][0]  <= tlb_wmat0;
            mat_q[tlb_windex][1]  <= tlb_wmat1;
            plv_q[tlb_windex][0]  <= tlb_wplv0;
            plv_q[tlb_windex][1]  <= tlb_wplv1;
            d_q[0][tlb_windex]    <= tlb_wd0;
            d_q[1][tlb_windex]    <= tlb_wd1;
            v_q[0][tlb_windex]    <= tlb_wv0;
            v_q[1][tlb_windex]    <= tlb_wv1;
        end
    end

endmodule

`default_nettype wire

// File: tlb/tlb_match.sv
`default_nettype none
`include "mmu_cfg.svh"

module tlb_match import mmu_pkg::*; (
    input  logic [`TLB_NUM-1:0]            ent_e,
    input  logic [`TLB_NUM-1:0]            ent_g,
    input  logic [`TLB_NUM*`ASID_W-1:0]    ent_asid,
    input  logic [`TLB_NUM*`VPN2_W-1:0]    ent_vpn2,
    input  logic [`TLB_NUM*`PS_W-1:0]      ent_ps,
    input  logic [`TLB_NUM*`PFN_W-1:0]     ent_pfn0,
    input  logic [`TLB_NUM*2-1:0]          ent_mat0,
    input  logic [`TLB_NUM*2-1:0]          ent_plv0,
    input  logic [`TLB_NUM-1:0]            ent_d0,
    input  logic [`TLB_NUM-1:0]            ent_v0,
    input  logic [`TLB_NUM*`PFN_W-1:0]     ent_pfn1,
    input  logic [`TLB_NUM*2-1:0]          ent_mat1,
    input  logic [`TLB_NUM*2-1:0]          ent_plv1,
    input  logic [`TLB_NUM-1:0]            ent_d1,
    input  logic [`TLB_NUM-1:0]            ent_v1,
    input  vaddr_u                         hold_vaddr,
    input  logic [`ASID_W-1:0]             hold_asid,
    output logic                           hit,
    output logic [`PFN_W-1:0]              hit_pfn,
    output logic [1:0]                     hit_mat,
    output logic [1:0]                     hit_plv,
    output logic                           hit_d,
    output logic                           hit_v,
    output logic [`PS_W-1:0]               hit_ps
);
    localparam int N = `TLB_NUM;

    logic [N-1:0] match;
    logic [N-1:0] odd;

    for (genvar i = 0; i < N; i++) begin : g_cmp
        logic is_2m;
        logic [`VPN2_W-1:0] vpn2;

        assign is_2m = ent_ps[i*`PS_W +: `PS_W] == `PS_2M;
        assign vpn2  = ent_vpn2[i*`VPN2_W +: `VPN2_W];
        // 2 MB pages skip the low nine vpn2 bits
        assign match[i] = ent_e[i]
                        && (ent_g[i] || ent_asid[i*`ASID_W +: `ASID_W] == hold_asid)
                        && vpn2[18:9] == hold_vaddr.page.vpn2[18:9]
                        && (is_2m || vpn2[8:0] == hold_vaddr.page.vpn2[8:0]);
        assign odd[i] = is_2m ? hold_vaddr[21] : hold_vaddr.page.odd;
    end

    assign hit = |match;

    // match is one-hot, so OR-ing the masked fields picks the entry
    always_comb begin
        hit_pfn = '0;
        hit_mat = '0;
        hit_plv = '0;
        hit_d   = 1'b0;
        hit_v   = 1'b0;
        hit_ps  = '0;
        for (int i = 0; i < N; i++) begin
            if (match[i]) begin
                hit_pfn |= odd[i] ? ent_pfn1[i*`PFN_W +: `PFN_W]
                                  : ent_pfn0[i*`PFN_W +: `PFN_W];
                hit_mat |= odd[i] ? ent_mat1[i*2 +: 2] : ent_mat0[i*2 +: 2];
                hit_plv |= odd[i] ? ent_plv1[i*2 +: 2] : ent_plv0[i*2 +: 2];
                hit_d   |= odd[i] ? ent_d1[i] : ent_d0[i];
                hit_v   |= odd[i] ? ent_v1[i] : ent_v0[i];
                hit_ps  |= ent_ps[i*`PS_W +: `PS_W];
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/mmu_tb.sv
`default_nettype none
`include "mmu_cfg.svh"

module mmu_tb;
    localparam int N = `TLB_NUM;

    logic clk, rst_n;
    logic req_valid, req_ready, resp_valid, resp_ready;
    logic [31:0] req_vaddr, resp_paddr, inv_vaddr;
    logic [`ASID_W-1:0] req_asid, tlb_wasid, inv_asid;
    logic [1:0] req_plv, req_mem_type, resp_mat, crmd_datm;
    logic [2:0] resp_exc, inv_op;
    logic crmd_da, dmw0_plv0, dmw0_plv3, dmw1_plv0, dmw1_plv3;
    logic [1:0] dmw0_mat, dmw1_mat;
    logic [2:0] dmw0_vseg, dmw0_pseg, dmw1_vseg, dmw1_pseg;
    logic tlb_we, tlb_we_bit, tlb_wg, tlb_wd0, tlb_wv0, tlb_wd1, tlb_wv1, inv_valid;
    logic [`TLB_IDX_W-1:0] tlb_windex;
    logic [`VPN2_W-1:0] tlb_wvpn2;
    logic [`PS_W-1:0] tlb_wps;
    logic [`PFN_W-1:0] tlb_wpfn0, tlb_wpfn1;
    logic [1:0] tlb_wmat0, tlb_wplv0, tlb_wmat1, tlb_wplv1;

    // reference copy of the tlb
    logic m_e [N];
    logic m_g [N];
    logic [`ASID_W-1:0] m_asid [N];
    logic [`VPN2_W-1:0] m_vpn2 [N];
    logic [`PS_W-1:0] m_ps [N];
    logic [`PFN_W-1:0] m_pfn [N][2];
    logic [1:0] m_plv [N][2];
    logic m_d [N][2];
    logic m_v [N][2];

    logic [36:0] exp_q [$];
    int acc_q [$];
    int cyc, errors, tests_ok, tests_bad;
    logic lat_chk, rnd_ready, stall_q;
    logic [36:0] held_q;

    mmu_top mmu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        resp_ready <= rnd_ready ? ($urandom % 2) != 0 : 1'b1;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout while %s", what);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // checks order, values, stall hold and latency of responses
    always @(posedge clk) begin
        logic [36:0] e;
        int a;
        cyc <= cyc + 1;
        if (rst_n) begin
            if (stall_q) begin
                check_val("resp_valid (stalled)", 32'(resp_valid), 32'd1);
                check_val("resp_paddr (stalled)", resp_paddr, held_q[36:5]);
                check_val("resp_mat (stalled)", 32'(resp_mat), 32'(held_q[4:3]));
                check_val("resp_exc (stalled)", 32'(resp_exc), 32'(held_q[2:0]));
            end
            if (resp_valid && resp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("response at %0t with no request outstanding", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    a = acc_q.pop_front();
                    check_val("resp_paddr", resp_paddr, e[36:5]);
                    check_val("resp_mat", 32'(resp_mat), 32'(e[4:3]));
                    check_val("resp_exc", 32'(resp_exc), 32'(e[2:0]));
                    if (lat_chk)
                        check_val("latency", 32'(cyc - a), 32'd2);
                end
            end
        end
        stall_q <= rst_n && resp_valid && !resp_ready;
        held_q  <= {resp_paddr, resp_mat, resp_exc};
    end

    function automatic logic [36:0] model_xlat(input logic [31:0] va, input logic [9:0] asid,
                                              input logic [1:0] plv, input logic [1:0] mt);
        logic [31:0] pa;
        logic [1:0] mat;
        logic [2:0] exc;
        logic ok0, ok1, odd, is_2m;
        int h;
        pa = '0;
        mat = '0;
        exc = `EXC_NONE;
        h = -1;
        ok0 = dmw0_vseg == va[31:29] && ((plv == 0 && dmw0_plv0) || (plv == 3 && dmw0_plv3));
        ok1 = dmw1_vseg == va[31:29] && ((plv == 0 && dmw1_plv0) || (plv == 3 && dmw1_plv3));
        if (crmd_da) begin
            pa = va;
            mat = crmd_datm;
        end else if (ok0) begin
            pa = {dmw0_pseg, va[28:0]};
            mat = dmw0_mat;
        end else if (ok1) begin
            pa = {dmw1_pseg, va[28:0]};
            mat = dmw1_mat;
        end else begin
            for (int i = 0; i < N; i++)
                if (m_e[i] && (m_g[i] || m_asid[i] == asid)
                    && (m_ps[i] == `PS_2M ? m_vpn2[i][18:9] == va[31:22]
                                          : m_vpn2[i] == va[31:13]))
                    h = i;
            if (h < 0) begin
                exc = `EXC_TLBR;
            end else begin
                is_2m = m_ps[h] == `PS_2M;
                odd = is_2m ? va[21] : va[12];
                if (!m_v[h][odd])
                    exc = mt == `MEM_FETCH ? `EXC_PIF : mt == `MEM_STORE ? `EXC_PIS : `EXC_PIL;
                else if (plv > m_plv[h][odd])
                    exc = `EXC_PPI;
                else if (mt == `MEM_STORE && !m_d[h][odd])
                    exc = `EXC_PME;
                else begin
                    pa = is_2m ? {m_pfn[h][odd][19:9], va[20:0]} : {m_pfn[h][odd], va[11:0]};
                    mat = odd ? 2'd2 : 2'd1;
                end
            end
        end
        return {pa, mat, exc};
    endfunction

    // called on a rising edge, returns on the edge of acceptance
    task automatic send(input logic [31:0] va, input logic [9:0] asid, input logic [1:0] plv,
                        input logic [1:0] mt);
        int n;
        n = 0;
        exp_q.push_back(model_xlat(va, asid, plv, mt));
        req_valid <= 1'b1;
        req_vaddr <= va;
        req_asid <= asid;
        req_plv <= plv;
        req_mem_type <= mt;
        do begin
            @(posedge clk);
            n++;
        end while (!req_ready && n < 200);
        if (!req_ready)
            abort_run("waiting for req_ready");
        else
            acc_q.push_back(cyc);
    endtask

    task automatic drain();
        int n;
        n = 0;
        req_valid <= 1'b0;
        while (exp_q.size() != 0 && n < 500) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0)
            abort_run("waiting for responses");
        else
            @(posedge clk);
    endtask

    task automatic ent_write(input int idx, input logic [18:0] vpn2, input logic [9:0] asid,
                             input logic [5:0] ps, input logic g, input logic [19:0] pfn0,
                             input logic [19:0] pfn1, input logic v0, input logic v1,
                             input logic d1, input logic [1:0] plv0, input logic [1:0] plv1);
        tlb_we <= 1'b1;
        tlb_windex <= idx[`TLB_IDX_W-1:0];
        tlb_wvpn2 <= vpn2;
        tlb_wasid <= asid;
        tlb_wps <= ps;
        tlb_we_bit <= 1'b1;
        tlb_wg <= g;
        tlb_wpfn0 <= pfn0;
        tlb_wpfn1 <= pfn1;
        tlb_wv0 <= v0;
        tlb_wv1 <= v1;
        tlb_wd0 <= 1'b1;
        tlb_wd1 <= d1;
        tlb_wplv0 <= plv0;
        tlb_wplv1 <= plv1;
        {m_e[idx], m_g[idx], m_asid[idx], m_vpn2[idx], m_ps[idx]} = {1'b1, g, asid, vpn2, ps};
        {m_pfn[idx][0], m_pfn[idx][1], m_v[idx][0], m_v[idx][1]} = {pfn0, pfn1, v0, v1};
        {m_d[idx][0], m_d[idx][1], m_plv[idx][0], m_plv[idx][1]} = {1'b1, d1, plv0, plv1};
        @(posedge clk);
        tlb_we <= 1'b0;
    endtask

    task automatic load_all();
        ent_write(0, 19'h00010, 10'd5, `PS_4K, 1'b0, 20'h11111, 20'h22222, 1, 1, 1, 3, 3);
        ent_write(1, {10'h050, 9'h0}, 10'd0, `PS_2M, 1'b1, 20'h40000, 20'h40200, 1, 1, 1, 3, 3);
        // pair with an invalid even half and a clean odd half
        ent_write(2, 19'h00020, 10'd7, `PS_4K, 1'b0, 20'h33333, 20'h44444, 0, 1, 0, 3, 3);
        ent_write(3, 19'h00030, 10'd7, `PS_4K, 1'b0, 20'h55555, 20'h66666, 1, 1, 1, 0, 3);
    endtask

    task automatic invtlb(input logic [2:0] op, input logic [9:0] asid, input logic [31:0] va);
        inv_valid <= 1'b1;
        inv_op <= op;
        inv_asid <= asid;
        inv_vaddr <= va;
        for (int i = 0; i < N; i++)
            if (op <= 1 || (op == 2 && m_g[i]) || (op == 3 && !m_g[i])
                || (op == 4 && !m_g[i] && m_asid[i] == asid)
                || (op == 5 && !m_g[i] && m_asid[i] == asid && m_vpn2[i] == va[31:13])
                || (op == 6 && (m_g[i] || m_asid[i] == asid) && m_vpn2[i] == va[31:13]))
                m_e[i] = 1'b0;
        @(posedge clk);
        inv_valid <= 1'b0;
    endtask

    task automatic probe_all();
        send({19'h00010, 1'b0, 12'h1a4}, 10'd5, 2'd3, `MEM_LOAD);
        send({19'h00010, 1'b1, 12'h1a4}, 10'd5, 2'd3, `MEM_STORE);
        send({10'h050, 1'b0, 21'h0abcd}, 10'd9, 2'd3, `MEM_LOAD);
        send({10'h050, 1'b1, 21'h0abcd}, 10'd9, 2'd0, `MEM_FETCH);
        send({19'h00020, 1'b1, 12'h010}, 10'd7, 2'd3, `MEM_LOAD);
        send({19'h00030, 1'b1, 12'h010}, 10'd7, 2'd0, `MEM_STORE);
        drain();
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int e0;
        void'($urandom(32'h419f_6cf3));
        {rst_n, req_valid, resp_ready, crmd_da, tlb_we, inv_valid} = '0;
        {req_vaddr, req_asid, req_plv, req_mem_type, crmd_datm, inv_op, inv_asid} = '0;
        {dmw0_plv0, dmw0_plv3, dmw0_mat, dmw1_plv0, dmw1_plv3, dmw1_mat} = '0;
        {dmw0_vseg, dmw0_pseg, dmw1_vseg, dmw1_pseg, inv_vaddr} = '0;
        {tlb_windex, tlb_wvpn2, tlb_wasid, tlb_wps, tlb_we_bit, tlb_wg} = '0;
        {tlb_wpfn0, tlb_wmat0, tlb_wplv0, tlb_wd0, tlb_wv0} = '0;
        {tlb_wpfn1, tlb_wplv1, tlb_wd1, tlb_wv1} = '0;
        tlb_wmat0 = 2'd1;
        tlb_wmat1 = 2'd2;
        {cyc, errors, tests_ok, tests_bad, stall_q, rnd_ready} = '0;
        lat_chk = 1'b1;
        for (int i = 0; i < N; i++)
            m_e[i] = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_val("resp_valid", 32'(resp_valid), 32'd0);
        check_val("req_ready", 32'(req_ready), 32'd1);

        e0 = errors;
        crmd_da <= 1'b1;
        crmd_datm <= 2'd1;
        @(posedge clk);
        repeat (8)
            send($urandom, 10'($urandom), 2'd3, 2'($urandom % 3));
        drain();
        crmd_da <= 1'b0;
        @(posedge clk);
        end_test("direct mode", e0);

        e0 = errors;
        {dmw0_vseg, dmw0_pseg, dmw0_plv0, dmw0_plv3, dmw0_mat} <= {3'd4, 3'd0, 1'b1, 1'b0, 2'd1};
        {dmw1_vseg, dmw1_pseg, dmw1_plv0, dmw1_plv3, dmw1_mat} <= {3'd4, 3'd2, 1'b1, 1'b1, 2'd0};
        @(posedge clk);
        send(32'h8123_4567, 10'd1, 2'd0, `MEM_LOAD);
        send(32'h8765_4320, 10'd1, 2'd3, `MEM_STORE);
        send(32'h8000_0040, 10'd1, 2'd1, `MEM_LOAD);
        send(32'ha000_0040, 10'd1, 2'd0, `MEM_FETCH);
        drain();
        {dmw0_vseg, dmw0_plv0, dmw1_vseg, dmw1_plv0, dmw1_plv3} <= {3'd7, 1'b0, 3'd7, 2'b00};
        @(posedge clk);
        end_test("windows", e0);

        e0 = errors;
        load_all();
        probe_all();
        send({19'h00010, 1'b0, 12'h004}, 10'd6, 2'd3, `MEM_LOAD);
        drain();
        end_test("tlb translation", e0);

        e0 = errors;
        send({19'h00020, 1'b0, 12'h008}, 10'd7, 2'd0, `MEM_FETCH);
        send({19'h00020, 1'b0, 12'h008}, 10'd7, 2'd0, `MEM_LOAD);
        send({19'h00020, 1'b0, 12'h008}, 10'd7, 2'd0, `MEM_STORE);
        send({19'h00020, 1'b1, 12'h008}, 10'd7, 2'd0, `MEM_STORE);
        send({19'h00030, 1'b0, 12'h008}, 10'd7, 2'd3, `MEM_LOAD);
        send({19'h00030, 1'b0, 12'h008}, 10'd7, 2'd0, `MEM_LOAD);
        drain();
        end_test("page exceptions", e0);

        e0 = errors;
        invtlb(3'd5, 10'd5, {19'h00010, 13'h0});
        probe_all();
        invtlb(3'd4, 10'd7, 32'h0);
        probe_all();
        load_all();
        invtlb(3'd6, 10'd0, {10'h050, 22'h0});
        probe_all();
        load_all();
        invtlb(3'd3, 10'd0, 32'h0);
        probe_all();
        load_all();
        invtlb(3'd2, 10'd0, 32'h0);
        probe_all();
        invtlb(3'd0, 10'd0, 32'h0);
        probe_all();
        end_test("invtlb", e0);

        e0 = errors;
        load_all();
        lat_chk <= 1'b0;
        rnd_ready <= 1'b1;
        @(posedge clk);
        for (int k = 0; k < 40; k++) begin
            logic [31:0] va;
            case ($urandom % 4)
                0: va = {19'h00010, 13'($urandom)};
                1: va = {10'h050, 22'($urandom)};
                2: va = {19'h00020, 13'($urandom)};
                default: va = {19'h00030, 13'($urandom)};
            endcase
            send(va, ($urandom % 2) != 0 ? 10'd5 : 10'd7, ($urandom % 2) != 0 ? 2'd3 : 2'd0,
                 2'($urandom % 3));
        end
        drain();
        rnd_ready <= 1'b0;
        @(posedge clk);
        end_test("back-pressure", e0);

        $display("tests ok %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/dmw_check.sv
`default_nettype none

module dmw_check import mmu_pkg::*; (
    input  vaddr_u      hold_vaddr,
    input  logic [1:0]  hold_plv,
    input  logic        dmw0_plv0,
    input  logic        dmw0_plv3,
    input  logic [1:0]  dmw0_mat,
    input  logic [2:0]  dmw0_vseg,
    input  logic [2:0]  dmw0_pseg,
    input  logic        dmw1_plv0,
    input  logic        dmw1_plv3,
    input  logic [1:0]  dmw1_mat,
    input  logic [2:0]  dmw1_vseg,
    input  logic [2:0]  dmw1_pseg,
    output logic        dmw_hit,
    output logic [31:0] dmw_paddr,
    output logic [1:0]  dmw_mat
);
    logic win0_hit;
    logic win1_hit;

    function automatic logic win_ok(input logic [2:0] vseg, input logic plv0,
                                    input logic plv3, input logic [2:0] seg,
                                    input logic [1:0] plv);
        return vseg == seg
            && ((plv == 2'd0 && plv0) || (plv == 2'd3 && plv3));
    endfunction

    assign win0_hit = win_ok(dmw0_vseg, dmw0_plv0, dmw0_plv3, hold_vaddr.win.vseg, hold_plv);
    assign win1_hit = win_ok(dmw1_vseg, dmw1_plv0, dmw1_plv3, hold_vaddr.win.vseg, hold_plv);
    assign dmw_hit  = win0_hit || win1_hit;

    // window 0 first
    assign dmw_paddr = {win0_hit ? dmw0_pseg : dmw1_pseg, hold_vaddr.win.offset};
    assign dmw_mat   = win0_hit ? dmw0_mat : dmw1_mat;

endmodule

`default_nettype wire

// File: verilog/lookup_req.sv
`default_nettype none
`include "mmu_cfg.svh"

module lookup_req import mmu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    output logic               req_ready,
    input  logic [31:0]        req_vaddr,
    input  logic [`ASID_W-1:0] req_asid,
    input  logic [1:0]         req_plv,
    input  logic [1:0]         req_mem_type,
    input  logic               take,
    output logic               hold_valid,
    output vaddr_u             hold_vaddr,
    output logic [`ASID_W-1:0] hold_asid,
    output logic [1:0]         hold_plv,
    output logic [1:0]         hold_mem_type
);
    // free slot, or the held one leaves this cycle
    assign req_ready = !hold_valid || take;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            hold_valid <= 1'b0;
        else if (req_ready)
            hold_valid <= req_valid;
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            hold_vaddr    <= req_vaddr;
            hold_asid     <= req_asid;
            hold_plv      <= req_plv;
            hold_mem_type <= req_mem_type;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mmu_top.sv
`default_nettype none
`include "mmu_cfg.svh"

module mmu_top import mmu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic [31:0]           req_vaddr,
    input  logic [`ASID_W-1:0]    req_asid,
    input  logic [1:0]            req_plv,
    input  logic [1:0]            req_mem_type,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output logic [31:0]           resp_paddr,
    output logic [1:0]            resp_mat,
    output logic [2:0]            resp_exc,
    input  logic                  crmd_da,
    input  logic [1:0]            crmd_datm,
    input  logic                  dmw0_plv0,
    input  logic                  dmw0_plv3,
    input  logic [1:0]            dmw0_mat,
    input  logic [2:0]            dmw0_vseg,
    input  logic [2:0]            dmw0_pseg,
    input  logic                  dmw1_plv0,
    input  logic                  dmw1_plv3,
    input  logic [1:0]            dmw1_mat,
    input  logic [2:0]            dmw1_vseg,
    input  logic [2:0]            dmw1_pseg,
    input  logic                  tlb_we,
    input  logic [`TLB_IDX_W-1:0] tlb_windex,
    input  logic [`VPN2_W-1:0]    tlb_wvpn2,
    input  logic [`ASID_W-1:0]    tlb_wasid,
    input  logic [`PS_W-1:0]      tlb_wps,
    input  logic                  tlb_we_bit,
    input  logic                  tlb_wg,
    input  logic [`PFN_W-1:0]     tlb_wpfn0,
    input  logic [1:0]            tlb_wmat0,
    input  logic [1:0]            tlb_wplv0,
    input  logic                  tlb_wd0,
    input  logic                  tlb_wv0,
    input  logic [`PFN_W-1:0]     tlb_wpfn1,
    input  logic [1:0]            tlb_wmat1,
    input  logic [1:0]            tlb_wplv1,
    input  logic                  tlb_wd1,
    input  logic                  tlb_wv1,
    input  logic                  inv_valid,
    input  logic [2:0]            inv_op,
    input  logic [`ASID_W-1:0]    inv_asid,
    input  logic [31:0]           inv_vaddr
);
    logic                         take;
    logic                         hold_valid;
    vaddr_u                       hold_vaddr;
    logic [`ASID_W-1:0]           hold_asid;
    logic [1:0]                   hold_plv;
    logic [1:0]                   hold_mem_type;
    logic [`TLB_NUM-1:0]          ent_e, ent_g, ent_d0, ent_v0, ent_d1, ent_v1;
    logic [`TLB_NUM*`ASID_W-1:0]  ent_asid;
    logic [`TLB_NUM*`VPN2_W-1:0]  ent_vpn2;
    logic [`TLB_NUM*`PS_W-1:0]    ent_ps;
    logic [`TLB_NUM*`PFN_W-1:0]   ent_pfn0, ent_pfn1;
    logic [`TLB_NUM*2-1:0]        ent_mat0, ent_plv0, ent_mat1, ent_plv1;
    logic                         hit, hit_d, hit_v;
    logic [`PFN_W-1:0]            hit_pfn;
    logic [1:0]                   hit_mat, hit_plv;
    logic [`PS_W-1:0]             hit_ps;
    logic                         dmw_hit;
    logic [31:0]                  dmw_paddr;
    logic [1:0]                   dmw_mat;

    lookup_req lookup_req_i (.*);

    tlb_array tlb_array_i (.*);

    tlb_match tlb_match_i (.*);

    dmw_check dmw_check_i (.*);

    xlat_resp xlat_resp_i (.*);

endmodule

`default_nettype wire

// File: verilog/xlat_resp.sv
`default_nettype none
`include "mmu_cfg.svh"

module xlat_resp import mmu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hold_valid,
    input  vaddr_u            hold_vaddr,
    input  logic [1:0]        hold_plv,
    input  logic [1:0]        hold_mem_type,
    input  logic              crmd_da,
    input  logic [1:0]        crmd_datm,
    input  logic              hit,
    input  logic [`PFN_W-1:0] hit_pfn,
    input  logic [1:0]        hit_mat,
    input  logic [1:0]        hit_plv,
    input  logic              hit_d,
    input  logic              hit_v,
    input  logic [`PS_W-1:0]  hit_ps,
    input  logic              dmw_hit,
    input  logic [31:0]       dmw_paddr,
    input  logic [1:0]        dmw_mat,
    output logic              take,
    input  logic              resp_ready,
    output logic              resp_valid,
    output logic [31:0]       resp_paddr,
    output logic [1:0]        resp_mat,
    output logic [2:0]        resp_exc
);
    logic [31:0] paddr;
    logic [1:0]  mat;
    logic [2:0]  exc;

    assign take = hold_valid && (!resp_valid || resp_ready);

    always_comb begin
        paddr = '0;
        mat   = '0;
        exc   = `EXC_NONE;
        if (crmd_da) begin
            paddr = hold_vaddr;
            mat   = crmd_datm;
        end else if (dmw_hit) begin
            paddr = dmw_paddr;
            mat   = dmw_mat;
        end else if (!hit) begin
            exc = `EXC_TLBR;
        end else if (!hit_v) begin
            case (hold_mem_type)
                `MEM_FETCH: exc = `EXC_PIF;
                `MEM_STORE: exc = `EXC_PIS;
                default:    exc = `EXC_PIL;
            endcase
        end else if (hold_plv > hit_plv) begin
            exc = `EXC_PPI;
        end else if (hold_mem_type == `MEM_STORE && !hit_d) begin
            exc = `EXC_PME;
        end else begin
            // offset width follows the page size
            if (hit_ps == `PS_2M)
                paddr = {hit_pfn[19:9], hold_vaddr[20:0]};
            else
                paddr = {hit_pfn, hold_vaddr.page.pg_off};
            mat = hit_mat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            resp_valid <= 1'b0;
        else if (take)
            resp_valid <= 1'b1;
        else if (resp_ready)
            resp_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            resp_paddr <= paddr;
            resp_mat   <= mat;
            resp_exc   <= exc;
        end
    end

endmodule

`default_nettype wire
